/* fetch_unit.f */
verilog/fetch_pkg.sv
verilog/line_buffer.sv
verilog/byte_aligner.sv
verilog/read_tracker.sv
verilog/fetch_ctrl.sv
verilog/fetch_unit.sv
testbench/tb_fetch_unit.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing -Wno-fatal --top-module tb_fetch_unit \
   -f fetch_unit.f -o sim_fetch_unit
./obj_dir/sim_fetch_unit

/* testbench/tb_fetch_unit.sv */
// fetch unit testbench: clock, reset, icache model, directed tests, compare tasks, watchdog
`timescale 1ns/1ps

module tb_fetch_unit;

   localparam int NUM_LINES  = 4;
   localparam int CLK_PERIOD = 4;
   localparam int MAX_DELAY  = 4;
   localparam int NUM_ADV    = 60;
   localparam int WAIT_LIMIT = 64;
   // cycles of all tests if every cache answer took one cycle
   localparam int TEST_CYCLES = 20 + 40 + NUM_ADV * 4 + 80 + 60 + 30;

   logic                   CLK;
   logic                   rst_n;
   fetch_pkg::redirect_t   redirect;
   fetch_pkg::consume_t    advance;
   fetch_pkg::icache_req_t icache_req;
   fetch_pkg::icache_rsp_t icache_rsp;
   fetch_pkg::line_t       window;
   logic                   window_valid;
   fetch_pkg::lin_addr_t   eip_out;

   integer               seed;
   fetch_pkg::lin_addr_t exp_eip;
   fetch_pkg::lin_addr_t exp_lin;
   // owned by the cache model
   fetch_pkg::lin_addr_t exp_fetch;
   fetch_pkg::lin_addr_t ans_addr;
   int                   completions;
   int                   wait_left;
   logic                 pending;

   fetch_unit #(
      .NUM_LINES (NUM_LINES)
   ) i_dut (
      .CLK          (CLK),
      .rst_n        (rst_n),
      .redirect     (redirect),
      .advance      (advance),
      .icache_req   (icache_req),
      .icache_rsp   (icache_rsp),
      .window       (window),
      .window_valid (window_valid),
      .eip_out      (eip_out)
   );

   initial begin
      CLK = 1'b0;
      forever begin
         #(CLK_PERIOD / 2);
         CLK = ~CLK;
      end
   end

   // memory content at linear address a
   function automatic logic [7:0] mem_byte(input fetch_pkg::lin_addr_t a);
      fetch_pkg::lin_addr_t x;
      x = a ^ (a >> 8) ^ (a >> 16) ^ (a >> 24);
      return x[7:0];
   endfunction

   function automatic fetch_pkg::line_t mem_line(input fetch_pkg::lin_addr_t a);
      fetch_pkg::line_t l;
      for (int i = 0; i < fetch_pkg::LINE_BYTES; i++) begin
         l[8*i +: 8] = mem_byte(a + 32'(i));
      end
      return l;
   endfunction

   task automatic stop_with_error(input string what);
      $display("%s", what);
      $display("Errors found");
      $fatal(1, "simulation stopped");
   endtask

   task automatic compare_line(input string name, input fetch_pkg::line_t act,
                               input fetch_pkg::line_t exp);
      if (act !== exp) begin
         stop_with_error($sformatf("ERR %s got %h expected %h", name, act, exp));
      end
   endtask

   task automatic compare_addr(input string name, input fetch_pkg::lin_addr_t act,
                               input fetch_pkg::lin_addr_t exp);
      if (act !== exp) begin
         stop_with_error($sformatf("ERR %s got %h expected %h", name, act, exp));
      end
   endtask

   task automatic compare_bit(input string name, input logic act, input logic exp);
      if (act !== exp) begin
         stop_with_error($sformatf("ERR %s got %h expected %h", name, act, exp));
      end
   endtask

   // icache model, acts once the stimulus of the falling edge has settled
   initial begin
      icache_rsp  = '0;
      exp_fetch   = '0;
      ans_addr    = '0;
      completions = 0;
      wait_left   = 0;
      pending     = 1'b0;
      forever begin
         @(negedge CLK);
         #1;
         if (icache_rsp.ready) begin
            // the answer was taken at the last rising edge
            compare_addr("icache_req.addr", ans_addr, exp_fetch);
            exp_fetch = exp_fetch + 32'd16;
            completions++;
            pending = 1'b0;
         end
         icache_rsp.ready = 1'b0;
         if (redirect.strobe) begin
            exp_fetch = redirect.eip + {redirect.cs, 16'h0000};
         end
         if (!icache_req.en) begin
            // withdrawn or no request
            pending = 1'b0;
         end else begin
            if (!pending) begin
               pending   = 1'b1;
               wait_left = $unsigned($random(seed)) % MAX_DELAY;
            end
            if (wait_left == 0) begin
               icache_rsp.ready = 1'b1;
               icache_rsp.data  = mem_line(icache_req.addr);
               ans_addr         = icache_req.addr;
            end else begin
               wait_left--;
            end
         end
      end
   end

   task automatic wait_valid();
      int n;
      n = 0;
      while (!window_valid) begin
         @(negedge CLK);
         n++;
         if (n > WAIT_LIMIT) begin
            stop_with_error("window_valid did not rise within the wait limit");
         end
      end
   endtask

   task automatic wait_completions(input int target);
      int n;
      n = 0;
      while (completions < target) begin
         @(negedge CLK);
         n++;
         if (n > WAIT_LIMIT) begin
            stop_with_error("the cache model saw fewer completed requests than expected");
         end
      end
   endtask

   task automatic do_redirect(input fetch_pkg::lin_addr_t eip, input fetch_pkg::seg_t cs);
      redirect.strobe = 1'b1;
      redirect.eip    = eip;
      redirect.cs     = cs;
      exp_eip         = eip;
      exp_lin         = eip + {cs, 16'h0000};
      @(negedge CLK);
      redirect = '0;
      compare_bit("window_valid", window_valid, 1'b0);
   endtask

   task automatic do_advance(input fetch_pkg::instr_len_t len);
      wait_valid();
      advance.strobe = 1'b1;
      advance.len    = len;
      exp_eip        = exp_eip + 32'(len);
      exp_lin        = exp_lin + 32'(len);
      @(negedge CLK);
      advance = '0;
   endtask

   task automatic check_window();
      wait_valid();
      compare_line("window", window, mem_line(exp_lin));
      compare_addr("eip_out", eip_out, exp_eip);
   endtask

   task automatic check_req_low(input int cycles);
      repeat (cycles) begin
         @(negedge CLK);
         compare_bit("icache_req.en", icache_req.en, 1'b0);
      end
   endtask

   task automatic test_idle_after_reset();
      repeat (20) begin
         @(negedge CLK);
         compare_bit("icache_req.en", icache_req.en, 1'b0);
         compare_bit("window_valid", window_valid, 1'b0);
      end
   endtask

   task automatic test_redirect_fill();
      int base;
      do_redirect(32'h0000_1234, 16'h0020);
      base = completions;
      wait_completions(base + 3);
      check_window();
   endtask

   task automatic test_random_advances();
      fetch_pkg::instr_len_t len;
      for (int i = 0; i < NUM_ADV; i++) begin
         len = 4'(1 + ($unsigned($random(seed)) % 15));
         do_advance(len);
         check_window();
      end
   endtask

   task automatic test_full_ring();
      int base;
      do_redirect(32'h0004_00f3, 16'h0011);
      base = completions;
      wait_completions(base + NUM_LINES);
      check_req_low(30);
      if (completions != base + NUM_LINES) begin
         stop_with_error("the cache answered more requests than the ring holds");
      end
      check_window();
      do_advance(4'd15);
      // one byte short of a free line
      check_req_low(5);
      check_window();
      do_advance(4'd1);
      wait_completions(base + NUM_LINES + 1);
      check_window();
   endtask

   task automatic test_redirect_outstanding();
      int base;
      int n;
      do_redirect(32'h0000_8ff7, 16'h0100);
      base = completions;
      wait_completions(base + 2);
      n = 0;
      while (!icache_req.en) begin
         @(negedge CLK);
         n++;
         if (n > WAIT_LIMIT) begin
            stop_with_error("no cache request was open before the second redirect");
         end
      end
      compare_bit("window_valid", window_valid, 1'b1);
      do_redirect(32'h0020_0009, 16'h0042);
      check_window();
      do_advance(4'd9);
      check_window();
      do_advance(4'd14);
      check_window();
   endtask

   task automatic test_advance_while_invalid();
      do_redirect(32'h0001_0ffa, 16'h0003);
      // window_valid is still low at the next edge
      advance.strobe = 1'b1;
      advance.len    = 4'd5;
      @(negedge CLK);
      advance = '0;
      compare_addr("eip_out", eip_out, exp_eip);
      check_window();
      do_advance(4'd7);
      check_window();
   endtask

   initial begin
      #(TEST_CYCLES * MAX_DELAY * 2 * CLK_PERIOD);
      stop_with_error("watchdog expired before the tests finished");
   end

   initial begin
      seed     = 32'hd27b;
      rst_n    = 1'b0;
      redirect = '0;
      advance  = '0;
      exp_eip  = '0;
      exp_lin  = '0;
      repeat (5) @(negedge CLK);
      rst_n = 1'b1;
      test_idle_after_reset();
      test_redirect_fill();
      test_random_advances();
      test_full_ring();
      test_redirect_outstanding();
      test_advance_while_invalid();
      $display("No errors");
      $finish;
   end

endmodule

/* verilog/byte_aligner.sv */
// byte aligner: builds the 16-byte window from the line ring at the read pointer
`timescale 1ns/1ps

module byte_aligner #(
   parameter int NUM_LINES = 4
) (
   input  fetch_pkg::line_t             lines [NUM_LINES],
   input  logic [$clog2(NUM_LINES)+3:0] rd_ptr,
   output fetch_pkg::line_t             window
);

   localparam int IDX_W  = $clog2(NUM_LINES);
   localparam int LINE_W = 8 * fetch_pkg::LINE_BYTES;

   logic [3:0]          byte_off;
   logic [IDX_W-1:0]    line_idx;
   logic [2*LINE_W-1:0] pair_sh [NUM_LINES];
   fetch_pkg::line_t    rot [NUM_LINES];

   // low bits pick the byte, upper bits pick the line
   assign byte_off = rd_ptr[3:0];
   assign line_idx = rd_ptr[IDX_W+3:4];

   // first level, each line shifted together with its successor
   for (genvar j = 0; j < NUM_LINES; j++) begin : g_pair
      // successor sits above so byte order follows the ring
      assign pair_sh[j] = {lines[(j + 1) % NUM_LINES], lines[j]} >> {byte_off, 3'b000};
      assign rot[j]     = pair_sh[j][LINE_W-1:0];
   end

   // second level, the pair holding the read pointer
   assign window = rot[line_idx];

endmodule

/* verilog/fetch_ctrl.sv */
// fetch controller: request fsm, fetch address, ring occupancy and line write control
`timescale 1ns/1ps

module fetch_ctrl #(
   parameter int NUM_LINES = 4
) (
   input  logic                         CLK,
   input  logic                         rst_n,
   input  fetch_pkg::redirect_t         redirect,
   input  fetch_pkg::consume_t          consumed,
   input  fetch_pkg::icache_rsp_t       icache_rsp,
   output fetch_pkg::icache_req_t       icache_req,
   output logic                         line_wr_strobe,
   output logic [$clog2(NUM_LINES)-1:0] line_wr_idx,
   output fetch_pkg::line_t             line_wr_data,
   output logic                         window_valid
);

   localparam int IDX_W = $clog2(NUM_LINES);
   // occupancy runs 0 to NUM_LINES*16 inclusive
   localparam int OCC_W = IDX_W + 5;
   localparam logic [OCC_W-1:0] RING_BYTES = OCC_W'(NUM_LINES * fetch_pkg::LINE_BYTES);
   localparam logic [OCC_W-1:0] STEP = OCC_W'(fetch_pkg::LINE_BYTES);

   fetch_pkg::fetch_state_e state;
   fetch_pkg::lin_addr_t    fetch_addr;
   fetch_pkg::lin_addr_t    redirect_lin;
   logic [IDX_W-1:0]        wr_idx;
   logic [OCC_W-1:0]        occ;
   logic [OCC_W-1:0]        occ_nxt;
   logic                    line_done;
   logic                    room;

   // linear address is eip plus cs shifted up by 16
   assign redirect_lin = redirect.eip + {redirect.cs, 16'h0000};

   // request only in st_request, and withdrawn in a redirect cycle
   assign icache_req.en   = (state == fetch_pkg::st_request) && !redirect.strobe;
   assign icache_req.addr = fetch_addr;
   assign line_done       = icache_req.en && icache_rsp.ready;

   // returned line goes straight into the next ring slot
   assign line_wr_strobe = line_done;
   assign line_wr_idx    = wr_idx;
   assign line_wr_data   = icache_rsp.data;

   // fill and drain at the same edge
   always_comb begin
      occ_nxt = occ;
      if (line_done) begin
         occ_nxt = occ_nxt + STEP;
      end
      if (consumed.strobe) begin
         occ_nxt = occ_nxt - OCC_W'(consumed.len);
      end
   end

   // another line fits without overwriting unread bytes
   assign room = (occ_nxt + STEP) <= RING_BYTES;

   always_ff @(posedge CLK or negedge rst_n) begin
      if (!rst_n) begin
         state        <= fetch_pkg::st_idle;
         fetch_addr   <= '0;
         wr_idx       <= '0;
         occ          <= '0;
         window_valid <= 1'b0;
      end else if (redirect.strobe) begin
         // flush the ring and restart at the new address
         state        <= fetch_pkg::st_request;
         fetch_addr   <= redirect_lin;
         wr_idx       <= '0;
         occ          <= '0;
         window_valid <= 1'b0;
      end else begin
         occ          <= occ_nxt;
         window_valid <= (occ_nxt >= STEP);
         if (line_done) begin
            fetch_addr <= fetch_addr + 32'(fetch_pkg::LINE_BYTES);
            wr_idx     <= wr_idx + 1'b1;
         end
         case (state)
            fetch_pkg::st_request: begin
               // keep en up back to back while there is room
               if (line_done && !room) begin
                  state <= fetch_pkg::st_full;
               end
            end
            fetch_pkg::st_full: begin
               if (room) begin
                  state <= fetch_pkg::st_request;
               end
            end
            default: begin
               // idle until a redirect
               state <= fetch_pkg::st_idle;
            end
         endcase
      end
   end

endmodule

/* verilog/fetch_pkg.sv */
// fetch unit package: line size, address and line types, fsm states, strobe and cache structs
package fetch_pkg;

   // bytes per cache line, also the width of the decode window
   localparam int LINE_BYTES = 16;

   // linear address or eip
   typedef logic [31:0] lin_addr_t;

   // code segment selector
   typedef logic [15:0] seg_t;

   // byte k of a line sits in bits 8k+7:8k, byte 0 is the lowest address
   typedef logic [8*LINE_BYTES-1:0] line_t;

   // instruction length in bytes
   typedef logic [3:0] instr_len_t;

   // fetch fsm states
   typedef enum logic [1:0] {
      st_idle,
      st_request,
      st_full
   } fetch_state_e;

   // control transfer, single cycle strobe
   typedef struct packed {
      logic      strobe;
      lin_addr_t eip;
      seg_t      cs;
   } redirect_t;

   // advance by len bytes, single cycle strobe
   typedef struct packed {
      logic       strobe;
      instr_len_t len;
   } consume_t;

   // request toward the icache, held until ready
   typedef struct packed {
      logic      en;
      lin_addr_t addr;
   } icache_req_t;

   // icache answer, data valid in the ready cycle
   typedef struct packed {
      logic  ready;
      line_t data;
   } icache_rsp_t;

endpackage

/* verilog/fetch_unit.sv */
// fetch unit top level: controller, line ring, byte aligner and read tracker
`timescale 1ns/1ps

module fetch_unit #(
   parameter int NUM_LINES = 4
) (
   input  logic                   CLK,
   input  logic                   rst_n,
   input  fetch_pkg::redirect_t   redirect,
   input  fetch_pkg::consume_t    advance,
   output fetch_pkg::icache_req_t icache_req,
   input  fetch_pkg::icache_rsp_t icache_rsp,
   output fetch_pkg::line_t       window,
   output logic                   window_valid,
   output fetch_pkg::lin_addr_t   eip_out
);

   localparam int IDX_W = $clog2(NUM_LINES);

   // advances that the read tracker let through
   fetch_pkg::consume_t consumed;

   // line write port into the ring
   logic             line_wr_strobe;
   logic [IDX_W-1:0] line_wr_idx;
   fetch_pkg::line_t line_wr_data;

   fetch_pkg::line_t lines [NUM_LINES];
   logic [IDX_W+3:0] rd_ptr;

   fetch_ctrl #(
      .NUM_LINES (NUM_LINES)
   ) i_fetch_ctrl (
      .CLK            (CLK),
      .rst_n          (rst_n),
      .redirect       (redirect),
      .consumed       (consumed),
      .icache_rsp     (icache_rsp),
      .icache_req     (icache_req),
      .line_wr_strobe (line_wr_strobe),
      .line_wr_idx    (line_wr_idx),
      .line_wr_data   (line_wr_data),
      .window_valid   (window_valid)
   );

   line_buffer #(
      .NUM_LINES (NUM_LINES)
   ) i_line_buffer (
      .CLK            (CLK),
      .rst_n          (rst_n),
      .line_wr_strobe (line_wr_strobe),
      .line_wr_idx    (line_wr_idx),
      .line_wr_data   (line_wr_data),
      .lines          (lines)
   );

   byte_aligner #(
      .NUM_LINES (NUM_LINES)
   ) i_byte_aligner (
      .lines  (lines),
      .rd_ptr (rd_ptr),
      .window (window)
   );

   read_tracker #(
      .NUM_LINES (NUM_LINES)
   ) i_read_tracker (
      .CLK          (CLK),
      .rst_n        (rst_n),
      .redirect     (redirect),
      .advance      (advance),
      .window_valid (window_valid),
      .consumed     (consumed),
      .rd_ptr       (rd_ptr),
      .eip_out      (eip_out)
   );

endmodule

/* verilog/line_buffer.sv */
// ring of fetched line registers with a single write port
`timescale 1ns/1ps

module line_buffer #(
   parameter int NUM_LINES = 4
) (
   input  logic                         CLK,
   input  logic                         rst_n,
   input  logic                         line_wr_strobe,
   input  logic [$clog2(NUM_LINES)-1:0] line_wr_idx,
   input  fetch_pkg::line_t             line_wr_data,
   output fetch_pkg::line_t             lines [NUM_LINES]
);

   localparam int IDX_W = $clog2(NUM_LINES);

   for (genvar i = 0; i < NUM_LINES; i++) begin : g_line
      logic wr_en;

      // slot select from the write index
      assign wr_en = line_wr_strobe && (line_wr_idx == IDX_W'(i));

      always_ff @(posedge CLK or negedge rst_n) begin
         if (!rst_n) begin
            lines[i] <= '0;
         end else if (wr_en) begin
            lines[i] <= line_wr_data;
         end
      end
   end

endmodule

/* verilog/read_tracker.sv */
// read tracker: read pointer and current eip, advance acceptance
`timescale 1ns/1ps

module read_tracker #(
   parameter int NUM_LINES = 4
) (
   input  logic                         CLK,
   input  logic                         rst_n,
   input  fetch_pkg::redirect_t         redirect,
   input  fetch_pkg::consume_t          advance,
   input  logic                         window_valid,
   output fetch_pkg::consume_t          consumed,
   output logic [$clog2(NUM_LINES)+3:0] rd_ptr,
   output fetch_pkg::lin_addr_t         eip_out
);

   localparam int PTR_W = $clog2(NUM_LINES) + 4;

   logic accept;

   // redirect wins over an advance in the same cycle
   assign accept = advance.strobe && window_valid && !redirect.strobe;

   // accepted step goes on to the controller for occupancy
   assign consumed.strobe = accept;
   assign consumed.len    = advance.len;

   always_ff @(posedge CLK or negedge rst_n) begin
      if (!rst_n) begin
         rd_ptr  <= '0;
         eip_out <= '0;
      end else if (redirect.strobe) begin
         rd_ptr  <= '0;
         eip_out <= redirect.eip;
      end else if (accept) begin
         // pointer wraps within the ring by its width
         rd_ptr  <= rd_ptr + PTR_W'(advance.len);
         eip_out <= eip_out + 32'(advance.len);
      end
   end

endmodule
